// ==== hw/tracker_defines.svh ====
`ifndef TRACKER_DEFINES_SVH
`define TRACKER_DEFINES_SVH

// pixel coordinates as they come from the camera side
`define TRK_X_W 11 // column, up to 2047
`define TRK_Y_W 10 // row, up to 1023

// colour data
`define TRK_CHAN_W 8 // one colour or luma/chroma channel
`define TRK_RGB565_W 16 // packed input pixel

// centre of mass accumulators
`define TRK_SUM_X_W 32 // sum of columns over a frame
`define TRK_SUM_Y_W 32 // sum of rows over a frame
`define TRK_CNT_W 21 // masked pixel count, covers a full 720p frame

// edges from input handshake to output handshake with no stall
`define TRK_PIPE_LAT 4

`endif

// ==== hw/tracker_pkg.sv ====
`include "tracker_defines.svh"

package tracker_pkg;

  // channel fed to the threshold, codes 3 and 7 give a zero channel
  typedef enum logic [2:0] {
    CH_GREEN = 3'd0,
    CH_RED   = 3'd1,
    CH_BLUE  = 3'd2,
    CH_LUMA  = 3'd4,
    CH_CR    = 3'd5,
    CH_CB    = 3'd6
  } channel_e;

  // what the output port shows
  typedef enum logic [1:0] {
    DISP_CAMERA    = 2'd0, // expanded camera pixel
    DISP_GRAY      = 2'd1, // selected channel as grey
    DISP_MASK      = 2'd2, // mask bit, white or black
    DISP_CROSSHAIR = 2'd3  // camera pixel with crosshair on the centre of mass
  } display_mode_e;

  typedef enum logic [1:0] {DIV_IDLE, DIV_DIVIDE, DIV_DONE} div_state_e;

  typedef logic [`TRK_X_W-1:0] x_coord_t;
  typedef logic [`TRK_Y_W-1:0] y_coord_t;

endpackage

// ==== hw/pixel_intake.sv ====
`timescale 1ns/10ps
`include "tracker_defines.svh"

module pixel_intake (
  input  logic                     clk_camera,
  input  logic                     sys_rst_pixel,
  input  logic                     pix_valid_i,
  output logic                     pix_ready_o,
  input  logic [`TRK_RGB565_W-1:0] pix_rgb565_i,
  input  tracker_pkg::x_coord_t    pix_x_i,
  input  tracker_pkg::y_coord_t    pix_y_i,
  input  logic                     pix_last_i,
  input  logic                     advance_i, // whole pipe moves this cycle
  output logic                     s1_valid_o,
  output logic [`TRK_CHAN_W-1:0]   s1_r_o,
  output logic [`TRK_CHAN_W-1:0]   s1_g_o,
  output logic [`TRK_CHAN_W-1:0]   s1_b_o,
  output tracker_pkg::x_coord_t    s1_x_o,
  output tracker_pkg::y_coord_t    s1_y_o,
  output logic                     s1_last_o
);
  import tracker_pkg::*;

  logic                   s1_valid_q;
  logic [`TRK_CHAN_W-1:0] s1_r_q, s1_g_q, s1_b_q;
  x_coord_t               s1_x_q;
  y_coord_t               s1_y_q;
  logic                   s1_last_q;

  // a pixel is taken whenever the pipe moves
  assign pix_ready_o = advance_i;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      s1_valid_q <= 1'b0;
    end else if (advance_i) begin
      s1_valid_q <= pix_valid_i; // empty slot when nothing offered
    end
  end

  // payload, 565 fields padded with zeros at the bottom
  always_ff @(posedge clk_camera) begin
    if (advance_i) begin
      s1_r_q    <= {pix_rgb565_i[15:11], 3'b000}; // 5 bit red
      s1_g_q    <= {pix_rgb565_i[10:5], 2'b00};   // 6 bit green
      s1_b_q    <= {pix_rgb565_i[4:0], 3'b000};   // 5 bit blue
      s1_x_q    <= pix_x_i;
      s1_y_q    <= pix_y_i;
      s1_last_q <= pix_last_i;
    end
  end

  assign s1_valid_o = s1_valid_q;
  assign s1_r_o     = s1_r_q;
  assign s1_g_o     = s1_g_q;
  assign s1_b_o     = s1_b_q;
  assign s1_x_o     = s1_x_q;
  assign s1_y_o     = s1_y_q;
  assign s1_last_o  = s1_last_q;

endmodule

// ==== hw/color_mask.sv ====
`timescale 1ns/10ps
`include "tracker_defines.svh"

module color_mask (
  input  logic                   clk_camera,
  input  logic                   sys_rst_pixel,
  input  logic                   advance_i,
  input  logic                   s1_valid_i,
  input  logic [`TRK_CHAN_W-1:0] s1_r_i,
  input  logic [`TRK_CHAN_W-1:0] s1_g_i,
  input  logic [`TRK_CHAN_W-1:0] s1_b_i,
  input  tracker_pkg::x_coord_t  s1_x_i,
  input  tracker_pkg::y_coord_t  s1_y_i,
  input  logic                   s1_last_i,
  input  tracker_pkg::channel_e  channel_sel_i,
  input  logic [`TRK_CHAN_W-1:0] lower_i, // inclusive
  input  logic [`TRK_CHAN_W-1:0] upper_i, // inclusive
  output logic                   s3_valid_o,
  output logic [`TRK_CHAN_W-1:0] s3_r_o,
  output logic [`TRK_CHAN_W-1:0] s3_g_o,
  output logic [`TRK_CHAN_W-1:0] s3_b_o,
  output logic [`TRK_CHAN_W-1:0] s3_chan_o,
  output logic                   s3_mask_o,
  output tracker_pkg::x_coord_t  s3_x_o,
  output tracker_pkg::y_coord_t  s3_y_o,
  output logic                   s3_last_o
);
  import tracker_pkg::*;

  localparam int ACC_W = 18; // holds +-112*255 with room to spare

  logic signed [ACC_W-1:0] r_s, g_s, b_s;
  logic signed [ACC_W-1:0] luma_acc, cr_acc, cb_acc;
  logic signed [ACC_W-1:0] luma_full, cr_full, cb_full;
  logic                    s2_valid_q;
  logic [`TRK_CHAN_W-1:0]  s2_r_q, s2_g_q, s2_b_q;
  logic [`TRK_CHAN_W-1:0]  s2_luma_q, s2_cr_q, s2_cb_q;
  x_coord_t                s2_x_q;
  y_coord_t                s2_y_q;
  logic                    s2_last_q;
  logic [`TRK_CHAN_W-1:0]  chan_sel;

  // stage 2 math, fixed point with 8 fraction bits
  always_comb begin
    r_s = $signed({{(ACC_W-`TRK_CHAN_W){1'b0}}, s1_r_i});
    g_s = $signed({{(ACC_W-`TRK_CHAN_W){1'b0}}, s1_g_i});
    b_s = $signed({{(ACC_W-`TRK_CHAN_W){1'b0}}, s1_b_i});
    luma_acc = 18'sd66 * r_s + 18'sd129 * g_s + 18'sd25 * b_s + 18'sd128;
    cr_acc = 18'sd112 * r_s - 18'sd94 * g_s - 18'sd18 * b_s + 18'sd128;
    cb_acc = -18'sd38 * r_s - 18'sd74 * g_s + 18'sd112 * b_s + 18'sd128;
    luma_full = (luma_acc >>> 8) + 18'sd16; // black sits at 16
    cr_full   = (cr_acc >>> 8) + 18'sd128;  // chroma centred on 128
    cb_full   = (cb_acc >>> 8) + 18'sd128;
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      s2_valid_q <= 1'b0;
      s3_valid_o <= 1'b0;
    end else if (advance_i) begin
      s2_valid_q <= s1_valid_i;
      s3_valid_o <= s2_valid_q;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (advance_i) begin
      s2_luma_q <= luma_full[`TRK_CHAN_W-1:0]; // truncate to 8 bits
      s2_cr_q   <= cr_full[`TRK_CHAN_W-1:0];
      s2_cb_q   <= cb_full[`TRK_CHAN_W-1:0];
      s2_r_q    <= s1_r_i;
      s2_g_q    <= s1_g_i;
      s2_b_q    <= s1_b_i;
      s2_x_q    <= s1_x_i;
      s2_y_q    <= s1_y_i;
      s2_last_q <= s1_last_i;
    end
  end

  // stage 3 channel select
  always_comb begin
    case (channel_sel_i)
      CH_GREEN: chan_sel = s2_g_q;
      CH_RED:   chan_sel = s2_r_q;
      CH_BLUE:  chan_sel = s2_b_q;
      CH_LUMA:  chan_sel = s2_luma_q;
      CH_CR:    chan_sel = s2_cr_q;
      CH_CB:    chan_sel = s2_cb_q;
      default:  chan_sel = '0; // unused codes 3 and 7
    endcase
  end

  always_ff @(posedge clk_camera) begin
    if (advance_i) begin
      s3_chan_o <= chan_sel;
      s3_mask_o <= s2_valid_q && (chan_sel >= lower_i) && (chan_sel <= upper_i);
      s3_r_o    <= s2_r_q;
      s3_g_o    <= s2_g_q;
      s3_b_o    <= s2_b_q;
      s3_x_o    <= s2_x_q;
      s3_y_o    <= s2_y_q;
      s3_last_o <= s2_last_q;
    end
  end

endmodule

// ==== hw/centroid_accum.sv ====
`timescale 1ns/10ps
`include "tracker_defines.svh"

module centroid_accum (
  input  logic                  clk_camera,
  input  logic                  sys_rst_pixel,
  input  logic                  advance_i,
  input  logic                  s3_valid_i,
  input  logic                  s3_mask_i,
  input  tracker_pkg::x_coord_t s3_x_i,
  input  tracker_pkg::y_coord_t s3_y_i,
  input  logic                  s3_last_i,
  output tracker_pkg::x_coord_t com_x_o,
  output tracker_pkg::y_coord_t com_y_o,
  output logic                  com_valid_o
);
  import tracker_pkg::*;

  localparam int QW     = `TRK_X_W + 1;   // quotient bits, one per divide cycle
  localparam int REM_W  = `TRK_CNT_W + 1; // remainder holds up to twice the count
  localparam int STEP_W = $clog2(QW);

  // one restoring step, returns {new remainder, quotient bit}
  function automatic logic [REM_W:0] div_step(input logic [REM_W-1:0] rem,
                                              input logic bit_in,
                                              input logic [`TRK_CNT_W-1:0] den);
    logic [REM_W-1:0] trial;
    trial = {rem[REM_W-2:0], bit_in};
    if (trial >= {1'b0, den}) begin
      return {trial - {1'b0, den}, 1'b1};
    end
    return {trial, 1'b0};
  endfunction

  div_state_e              state_q;
  logic [STEP_W-1:0]       step_q;
  logic [`TRK_SUM_X_W-1:0] sum_x_q, sum_x_nxt, sum_x_hi;
  logic [`TRK_SUM_Y_W-1:0] sum_y_q, sum_y_nxt, sum_y_hi;
  logic [`TRK_CNT_W-1:0]   cnt_q, cnt_nxt;
  logic [`TRK_CNT_W-1:0]   den_q;   // frame count frozen for the divide
  logic [`TRK_SUM_X_W-1:0] num_x_q; // dividend bits still to shift in
  logic [`TRK_SUM_Y_W-1:0] num_y_q;
  logic [REM_W-1:0]        rem_x_q, rem_y_q;
  logic [QW-1:0]           quo_x_q, quo_y_q;
  logic [REM_W:0]          step_x, step_y;
  logic                    hit, frame_end;

  assign hit       = advance_i && s3_valid_i && s3_mask_i;
  assign frame_end = advance_i && s3_valid_i && s3_last_i;

  // sums including the current pixel, so the last one lands in its own frame
  always_comb begin
    sum_x_nxt = sum_x_q + (hit ? `TRK_SUM_X_W'(s3_x_i) : '0);
    sum_y_nxt = sum_y_q + (hit ? `TRK_SUM_Y_W'(s3_y_i) : '0);
    cnt_nxt   = cnt_q + (hit ? `TRK_CNT_W'(1) : '0);
    sum_x_hi  = sum_x_nxt >> QW; // mean < 2^QW so this part is below the count
    sum_y_hi  = sum_y_nxt >> QW;
    step_x    = div_step(rem_x_q, num_x_q[`TRK_SUM_X_W-1], den_q);
    step_y    = div_step(rem_y_q, num_y_q[`TRK_SUM_Y_W-1], den_q);
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      sum_x_q <= '0;
      sum_y_q <= '0;
      cnt_q   <= '0;
    end else if (frame_end) begin
      sum_x_q <= '0; // next frame starts empty
      sum_y_q <= '0;
      cnt_q   <= '0;
    end else begin
      sum_x_q <= sum_x_nxt;
      sum_y_q <= sum_y_nxt;
      cnt_q   <= cnt_nxt;
    end
  end

  // divider FSM, x and y run side by side
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      state_q     <= DIV_IDLE;
      step_q      <= '0;
      com_x_o     <= '0;
      com_y_o     <= '0;
      com_valid_o <= 1'b0;
    end else begin
      com_valid_o <= 1'b0;
      case (state_q)
        DIV_IDLE: begin
          step_q <= '0;
          if (frame_end) state_q <= DIV_DIVIDE;
        end
        DIV_DIVIDE: begin
          step_q <= step_q + 1'b1;
          if (step_q == STEP_W'(QW - 1)) state_q <= DIV_DONE;
        end
        DIV_DONE: begin
          if (den_q != '0) begin // empty frame keeps the old centre
            com_x_o <= quo_x_q[`TRK_X_W-1:0];
            com_y_o <= quo_y_q[`TRK_Y_W-1:0];
          end
          com_valid_o <= 1'b1;
          state_q     <= DIV_IDLE;
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  // divider datapath
  always_ff @(posedge clk_camera) begin
    if (state_q == DIV_IDLE && frame_end) begin
      den_q   <= cnt_nxt;
      rem_x_q <= sum_x_hi[REM_W-1:0];
      rem_y_q <= sum_y_hi[REM_W-1:0];
      num_x_q <= sum_x_nxt << (`TRK_SUM_X_W - QW); // low QW bits up top
      num_y_q <= sum_y_nxt << (`TRK_SUM_Y_W - QW);
    end else if (state_q == DIV_DIVIDE) begin
      rem_x_q <= step_x[REM_W:1];
      rem_y_q <= step_y[REM_W:1];
      quo_x_q <= {quo_x_q[QW-2:0], step_x[0]};
      quo_y_q <= {quo_y_q[QW-2:0], step_y[0]};
      num_x_q <= num_x_q << 1;
      num_y_q <= num_y_q << 1;
    end
  end

endmodule

// ==== hw/overlay_out.sv ====
`timescale 1ns/10ps
`include "tracker_defines.svh"

module overlay_out (
  input  logic                       clk_camera,
  input  logic                       sys_rst_pixel,
  input  logic                       s3_valid_i,
  input  logic [`TRK_CHAN_W-1:0]     s3_r_i,
  input  logic [`TRK_CHAN_W-1:0]     s3_g_i,
  input  logic [`TRK_CHAN_W-1:0]     s3_b_i,
  input  logic [`TRK_CHAN_W-1:0]     s3_chan_i,
  input  logic                       s3_mask_i,
  input  tracker_pkg::x_coord_t      s3_x_i,
  input  tracker_pkg::y_coord_t      s3_y_i,
  input  logic                       s3_last_i,
  input  tracker_pkg::x_coord_t      com_x_i,
  input  tracker_pkg::y_coord_t      com_y_i,
  input  tracker_pkg::display_mode_e mode_i,
  input  logic                       out_ready_i,
  output logic                       advance_o,
  output logic                       out_valid_o,
  output logic [3*`TRK_CHAN_W-1:0]   out_rgb_o // {red, green, blue}
);
  import tracker_pkg::*;

  logic [3*`TRK_CHAN_W-1:0] cam_rgb, pix_rgb;
  logic                     on_cross;

  // register free or drained this cycle, so the whole pipe may move
  assign advance_o = !out_valid_o || out_ready_i;

  assign cam_rgb  = {s3_r_i, s3_g_i, s3_b_i};
  assign on_cross = (s3_x_i == com_x_i) || (s3_y_i == com_y_i);

  always_comb begin
    case (mode_i)
      DISP_CAMERA:    pix_rgb = cam_rgb;
      DISP_GRAY:      pix_rgb = {3{s3_chan_i}};
      DISP_MASK:      pix_rgb = {(3*`TRK_CHAN_W){s3_mask_i}};
      DISP_CROSSHAIR: pix_rgb = on_cross ? '1 : cam_rgb; // white lines
      default:        pix_rgb = cam_rgb;
    endcase
  end

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      out_valid_o <= 1'b0;
    end else if (advance_o) begin
      out_valid_o <= s3_valid_i;
    end
  end

  // held while stalled
  always_ff @(posedge clk_camera) begin
    if (advance_o) begin
      out_rgb_o <= pix_rgb;
    end
  end

endmodule

// ==== hw/blob_tracker_top.sv ====
`timescale 1ns/10ps
`include "tracker_defines.svh"

module blob_tracker_top (
  input  logic                       clk_camera,
  input  logic                       sys_rst_pixel,
  input  logic                       pix_valid_i,
  output logic                       pix_ready_o,
  input  logic [`TRK_RGB565_W-1:0]   pix_rgb565_i,
  input  tracker_pkg::x_coord_t      pix_x_i,
  input  tracker_pkg::y_coord_t      pix_y_i,
  input  logic                       pix_last_i,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic [3*`TRK_CHAN_W-1:0]   out_rgb_o,
  output tracker_pkg::x_coord_t      com_x_o,
  output tracker_pkg::y_coord_t      com_y_o,
  output logic                       com_valid_o,
  input  tracker_pkg::channel_e      channel_sel_i,
  input  logic [`TRK_CHAN_W-1:0]     lower_i,
  input  logic [`TRK_CHAN_W-1:0]     upper_i,
  input  tracker_pkg::display_mode_e mode_i
);
  import tracker_pkg::*;

  logic                   advance; // global pipe enable from the output side
  logic                   s1_valid, s1_last;
  logic [`TRK_CHAN_W-1:0] s1_r, s1_g, s1_b;
  x_coord_t               s1_x;
  y_coord_t               s1_y;
  logic                   s3_valid, s3_mask, s3_last;
  logic [`TRK_CHAN_W-1:0] s3_r, s3_g, s3_b, s3_chan;
  x_coord_t               s3_x;
  y_coord_t               s3_y;

  pixel_intake u_pixel_intake (
    .clk_camera, .sys_rst_pixel, .pix_valid_i, .pix_ready_o, .pix_rgb565_i,
    .pix_x_i, .pix_y_i, .pix_last_i, .advance_i(advance),
    .s1_valid_o(s1_valid), .s1_r_o(s1_r), .s1_g_o(s1_g), .s1_b_o(s1_b),
    .s1_x_o(s1_x), .s1_y_o(s1_y), .s1_last_o(s1_last));

  color_mask u_color_mask (
    .clk_camera, .sys_rst_pixel, .advance_i(advance),
    .s1_valid_i(s1_valid), .s1_r_i(s1_r), .s1_g_i(s1_g), .s1_b_i(s1_b),
    .s1_x_i(s1_x), .s1_y_i(s1_y), .s1_last_i(s1_last),
    .channel_sel_i, .lower_i, .upper_i,
    .s3_valid_o(s3_valid), .s3_r_o(s3_r), .s3_g_o(s3_g), .s3_b_o(s3_b),
    .s3_chan_o(s3_chan), .s3_mask_o(s3_mask), .s3_x_o(s3_x), .s3_y_o(s3_y),
    .s3_last_o(s3_last));

  // taps the mask at the stage 3 boundary
  centroid_accum u_centroid_accum (
    .clk_camera, .sys_rst_pixel, .advance_i(advance),
    .s3_valid_i(s3_valid), .s3_mask_i(s3_mask), .s3_x_i(s3_x), .s3_y_i(s3_y),
    .s3_last_i(s3_last), .com_x_o, .com_y_o, .com_valid_o);

  overlay_out u_overlay_out (
    .clk_camera, .sys_rst_pixel,
    .s3_valid_i(s3_valid), .s3_r_i(s3_r), .s3_g_i(s3_g), .s3_b_i(s3_b),
    .s3_chan_i(s3_chan), .s3_mask_i(s3_mask), .s3_x_i(s3_x), .s3_y_i(s3_y),
    .s3_last_i(s3_last), .com_x_i(com_x_o), .com_y_i(com_y_o), .mode_i,
    .out_ready_i, .advance_o(advance), .out_valid_o, .out_rgb_o);

endmodule

// ==== testbench/blob_tracker_asserts.sv ====
`timescale 1ns/10ps
`include "tracker_defines.svh"

module blob_tracker_asserts (
  input logic                     clk_camera,
  input logic                     sys_rst_pixel,
  input logic                     out_valid_o,
  input logic                     out_ready_i,
  input logic [3*`TRK_CHAN_W-1:0] out_rgb_o,
  input tracker_pkg::x_coord_t    com_x_o,
  input tracker_pkg::y_coord_t    com_y_o,
  input logic                     com_valid_o
);

  // stalled beat keeps valid and data
  stall_hold: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rgb_o))
    else $error("output pixel changed or dropped while stalled");

  com_pulse: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    com_valid_o |=> !com_valid_o)
    else $error("com_valid_o longer than one cycle");

  // centre only moves together with its pulse
  com_update: assert property (@(posedge clk_camera) disable iff (sys_rst_pixel)
    !$stable({com_x_o, com_y_o}) |-> com_valid_o)
    else $error("centre of mass changed without com_valid_o");

  reset_idle: assert property (@(posedge clk_camera)
    sys_rst_pixel |=> !out_valid_o && !com_valid_o)
    else $error("valid outputs high after reset");

endmodule

bind blob_tracker_top blob_tracker_asserts u_blob_tracker_asserts (
  .clk_camera(clk_camera),
  .sys_rst_pixel(sys_rst_pixel),
  .out_valid_o(out_valid_o),
  .out_ready_i(out_ready_i),
  .out_rgb_o(out_rgb_o),
  .com_x_o(com_x_o),
  .com_y_o(com_y_o),
  .com_valid_o(com_valid_o)
);

// ==== testbench/tb_blob_tracker.sv ====
`timescale 1ns/10ps
`include "tracker_defines.svh"

module tb_blob_tracker;
  import tracker_pkg::*;

  localparam int N_FRAMES = 20;
  localparam int FRAME_W  = 8;
  localparam int FRAME_H  = 8;
  localparam int WATCHDOG_CYCLES = N_FRAMES * 200 + 5; // plus the reset cycles

  logic                     clk_camera;
  logic                     sys_rst_pixel;
  logic                     pix_valid_i, pix_ready_o, pix_last_i;
  logic [`TRK_RGB565_W-1:0] pix_rgb565_i;
  x_coord_t                 pix_x_i, com_x_o;
  y_coord_t                 pix_y_i, com_y_o;
  logic                     out_valid_o, out_ready_i, com_valid_o;
  logic [3*`TRK_CHAN_W-1:0] out_rgb_o;
  channel_e                 channel_sel_i;
  logic [`TRK_CHAN_W-1:0]   lower_i, upper_i;
  display_mode_e            mode_i;

  integer      seed = 32'he3cd;       // stimulus stream
  integer      ready_seed = 32'he3cd; // back-pressure stream, kept apart
  logic [23:0] exp_q[$];              // expected output pixels in order
  logic [23:0] exp_rgb;
  int          out_count;
  int          com_pulses;
  logic        bp_en;
  string       test_name;
  int          model_com_x, model_com_y; // model centre of mass
  int          frame_mode, frame_chan, frame_lo, frame_hi;

  blob_tracker_top u_blob_tracker_top (.*);

  initial clk_camera = 1'b0;
  always #5 clk_camera = ~clk_camera; // 10 ns period

  // reference channel from RGB888, wraps to 8 bits like a truncated result
  function automatic int channel_value(input int code, input int r, input int g, input int b);
    int luma;
    int cr;
    int cb;
    luma = (((66 * r + 129 * g + 25 * b + 128) >>> 8) + 16) & 255;
    cr   = (((112 * r - 94 * g - 18 * b + 128) >>> 8) + 128) & 255;
    cb   = (((-38 * r - 74 * g + 112 * b + 128) >>> 8) + 128) & 255;
    case (code)
      0: return g;
      1: return r;
      2: return b;
      4: return luma;
      5: return cr;
      6: return cb;
      default: return 0; // codes 3 and 7
    endcase
  endfunction

  // expected output pixel for one display mode
  function automatic logic [23:0] display_pixel(input int mode, input int r, input int g,
                                                input int b, input int chan, input bit mask,
                                                input int x, input int y);
    logic [23:0] cam;
    cam = {8'(r), 8'(g), 8'(b)};
    case (mode)
      1: return {3{8'(chan)}};
      2: return mask ? 24'hffffff : 24'h000000;
      3: return (x == model_com_x || y == model_com_y) ? 24'hffffff : cam;
      default: return cam;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_run(input string why);
    $display("ERROR: %s", why);
    $display("Checks failed");
    $fatal(1, "stopped on error");
  endtask

  // frame config, only touched while the pipe is empty
  task automatic setup_frame(input int f);
    int lo;
    int hi;
    int tmp;
    lo = $random(seed) & 255;
    hi = $random(seed) & 255;
    if (lo > hi) begin
      tmp = lo;
      lo  = hi;
      hi  = tmp;
    end
    if (f == 0) begin
      frame_mode = 3; // crosshair on the reset centre
      frame_chan = 1;
    end else if (f == 1) begin
      frame_mode = 0;
      frame_chan = 4;
    end else if (f < 10) begin
      frame_mode = 1; // gray, every channel code
      frame_chan = f - 2;
    end else if (f < 18) begin
      frame_mode = 2; // mask, every channel code
      frame_chan = f - 10;
      if (frame_chan == 3 || frame_chan == 7) begin
        lo = 0; // zero channel sits right on both bounds
        hi = 0;
      end
    end else if (f == 18) begin
      frame_mode = 2;
      frame_chan = 4;
      lo = 255; // empty window, nothing masked
      hi = 0;
    end else begin
      frame_mode = 3; // crosshair after the empty frame
      frame_chan = 5;
    end
    frame_lo  = lo;
    frame_hi  = hi;
    test_name = $sformatf("frame %0d mode %0d chan %0d", f, frame_mode, frame_chan);
    @(posedge clk_camera);
    mode_i        <= display_mode_e'(2'(frame_mode));
    channel_sel_i <= channel_e'(3'(frame_chan));
    lower_i       <= 8'(lo);
    upper_i       <= 8'(hi);
    bp_en         <= (f % 2) == 1; // back-pressure on odd frames
  endtask

  // one raster frame with random idle gaps, model runs alongside
  task automatic send_frame();
    logic [15:0] rgb;
    int r;
    int g;
    int b;
    int chan;
    bit mask;
    int sum_x;
    int sum_y;
    int cnt;
    sum_x = 0;
    sum_y = 0;
    cnt   = 0;
    for (int y = 0; y < FRAME_H; y++) begin
      for (int x = 0; x < FRAME_W; x++) begin
        rgb = 16'($random(seed));
        if (($random(seed) & 3) == 0) begin
          @(posedge clk_camera);
          pix_valid_i <= 1'b0; // idle cycle
        end
        @(posedge clk_camera);
        pix_valid_i  <= 1'b1;
        pix_rgb565_i <= rgb;
        pix_x_i      <= x_coord_t'(x);
        pix_y_i      <= y_coord_t'(y);
        pix_last_i   <= (x == FRAME_W - 1) && (y == FRAME_H - 1);
        @(negedge clk_camera);
        while (!pix_ready_o) @(negedge clk_camera); // taken on the next edge
        r    = int'(rgb[15:11]) << 3;
        g    = int'(rgb[10:5]) << 2;
        b    = int'(rgb[4:0]) << 3;
        chan = channel_value(frame_chan, r, g, b);
        mask = (chan >= frame_lo) && (chan <= frame_hi);
        if (mask) begin
          sum_x += x;
          sum_y += y;
          cnt++;
        end
        exp_q.push_back(display_pixel(frame_mode, r, g, b, chan, mask, x, y));
      end
    end
    @(posedge clk_camera);
    pix_valid_i <= 1'b0;
    pix_last_i  <= 1'b0;
    if (cnt != 0) begin // empty frame keeps the old centre
      model_com_x = sum_x / cnt;
      model_com_y = sum_y / cnt;
    end
  endtask

  task automatic await_centroid();
    @(negedge clk_camera);
    while (!com_valid_o) @(negedge clk_camera);
    check_value({test_name, " com_x"}, 32'(model_com_x), 32'(com_x_o));
    check_value({test_name, " com_y"}, 32'(model_com_y), 32'(com_y_o));
    @(negedge clk_camera);
    if (com_valid_o) fail_run("com_valid_o stayed high for more than one cycle");
  endtask

  task automatic await_drain();
    while (exp_q.size() != 0) @(negedge clk_camera);
  endtask

  // random out_ready_i, low about one cycle in four
  always @(posedge clk_camera) begin
    if (bp_en) out_ready_i <= ($random(ready_seed) & 3) != 0;
    else out_ready_i <= 1'b1;
  end

  // output beats and centre pulses, sampled mid cycle
  always @(negedge clk_camera) begin
    if (!sys_rst_pixel && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        fail_run("output pixel appeared with none expected");
      end else begin
        exp_rgb = exp_q.pop_front();
        check_value($sformatf("%s pixel %0d", test_name, out_count), 32'(exp_rgb),
                    32'(out_rgb_o));
        out_count++;
      end
    end
    if (!sys_rst_pixel && com_valid_o) com_pulses++;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_camera);
    fail_run($sformatf("run did not finish within %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    sys_rst_pixel = 1'b1;
    pix_valid_i   = 1'b0;
    pix_rgb565_i  = '0;
    pix_x_i       = '0;
    pix_y_i       = '0;
    pix_last_i    = 1'b0;
    out_ready_i   = 1'b1;
    channel_sel_i = CH_GREEN;
    lower_i       = '0;
    upper_i       = '0;
    mode_i        = DISP_CAMERA;
    bp_en         = 1'b0;
    model_com_x   = 0;
    model_com_y   = 0;
    out_count     = 0;
    com_pulses    = 0;
    test_name     = "after reset";
    repeat (5) @(posedge clk_camera);
    sys_rst_pixel <= 1'b0;
    @(negedge clk_camera);
    check_value("after reset pix_ready_o", 32'd1, 32'(pix_ready_o));
    check_value("after reset out_valid_o", 32'd0, 32'(out_valid_o));
    check_value("after reset com_valid_o", 32'd0, 32'(com_valid_o));
    check_value("after reset com_x_o", 32'd0, 32'(com_x_o));
    check_value("after reset com_y_o", 32'd0, 32'(com_y_o));
    for (int f = 0; f < N_FRAMES; f++) begin
      setup_frame(f);
      send_frame();
      await_centroid();
      await_drain();
    end
    @(negedge clk_camera);
    check_value("output pixel count", 32'(N_FRAMES * FRAME_W * FRAME_H), 32'(out_count));
    check_value("com_valid_o pulse count", 32'(N_FRAMES), 32'(com_pulses));
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/tracker_pkg.sv
hw/pixel_intake.sv
hw/color_mask.sv
hw/centroid_accum.sv
hw/overlay_out.sv
hw/blob_tracker_top.sv
testbench/blob_tracker_asserts.sv
testbench/tb_blob_tracker.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the blob tracker testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_blob_tracker -f vlog.f -o sim_blob_tracker; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_blob_tracker 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "All checks passed" <<< "$sim_out"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
